// File: include/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// address and data widths
`define FE_IP_WIDTH 32
`define FE_INSN_WIDTH 32
`define FE_LINE_INSNS 4
`define FE_LINE_WIDTH 128

// threads and their start pointers
`define FE_NUM_THREADS 2
`define FE_RESET_IP 32'h0000_1000
`define FE_THREAD_IP_STEP 32'h0000_0100

// register index in the instruction word
`define FE_REG_WIDTH 6

`endif

// File: source/fe_pkg.sv
`include "fe_consts.svh"

package fe_pkg;

  // codes 0..4 come straight from word bits 31:28
  typedef enum logic [3:0] {
    op_nop     = 4'd0,
    op_alu     = 4'd1,
    op_load    = 4'd2,
    op_store   = 4'd3,
    op_branch  = 4'd4,
    op_illegal = 4'hf
  } opcode_e;

  typedef enum logic [1:0] {
    fill_idle,
    fill_req,
    fill_release
  } fill_state_e;

  typedef struct packed {
    logic                    valid;
    logic [`FE_IP_WIDTH-1:0] addr;
  } fetch_req_t;

  // word i of the line sits at bits 32*i+31 : 32*i
  typedef struct packed {
    logic                      valid;
    logic                      thread;
    logic [`FE_LINE_WIDTH-1:0] line;
  } fill_t;

  typedef struct packed {
    logic                      valid;
    logic                      thread;
    logic [`FE_IP_WIDTH-1:0]   ip;
    logic [`FE_INSN_WIDTH-1:0] word;
  } insn_t;

  typedef struct packed {
    logic                     valid;
    logic                     thread;
    logic [`FE_IP_WIDTH-1:0]  ip;
    opcode_e                  opcode;
    logic [`FE_REG_WIDTH-1:0] ra;
    logic [`FE_REG_WIDTH-1:0] rb;
    logic [`FE_REG_WIDTH-1:0] rt;
    logic                     rt_use;
    logic [31:0]              imm;
  } dec_insn_t;

endpackage

// File: source/line_fill_arbiter.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module line_fill_arbiter (
  input  logic                                   clk,
  input  logic                                   rst,
  input  fe_pkg::fetch_req_t [`FE_NUM_THREADS-1:0] thread_req,
  output logic                                   mem_req,
  output logic [`FE_IP_WIDTH-1:0]                mem_addr,
  input  logic                                   mem_ack,
  input  logic [`FE_LINE_WIDTH-1:0]              mem_data,
  output fe_pkg::fill_t                          fill
);

  fe_pkg::fill_state_e state_q;
  logic                    any_req;
  logic                    win;
  logic                    thr_q;
  logic [`FE_IP_WIDTH-1:0] addr_q;

  assign any_req = thread_req[0].valid || thread_req[1].valid;
  // thread 0 always wins a tie
  assign win = !thread_req[0].valid;

  assign mem_req  = (state_q == fe_pkg::fill_req);
  assign mem_addr = addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= fe_pkg::fill_idle;
      fill.valid <= 1'b0;
    end else begin
      fill.valid <= 1'b0;
      case (state_q)
        fe_pkg::fill_idle: begin
          if (any_req) begin
            thr_q   <= win;
            addr_q  <= thread_req[win].addr;
            state_q <= fe_pkg::fill_req;
          end
        end
        fe_pkg::fill_req: begin
          if (mem_ack) begin
            fill.valid  <= 1'b1;
            fill.thread <= thr_q;
            fill.line   <= mem_data;
            state_q     <= fe_pkg::fill_release;
          end
        end
        fe_pkg::fill_release: begin
          // wait for the slave to finish the four-phase cycle
          if (!mem_ack) begin
            state_q <= fe_pkg::fill_idle;
          end
        end
        default: begin
          state_q <= fe_pkg::fill_idle;
        end
      endcase
    end
  end

  a_req_held: assert property (
    @(posedge clk) disable iff (rst)
    $fell(mem_req) |-> $past(mem_ack)
  );

  a_addr_stable: assert property (
    @(posedge clk) disable iff (rst)
    mem_req && $past(mem_req) |-> $stable(mem_addr)
  );

endmodule

// File: source/fetch_thread.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module fetch_thread #(
  parameter int thread_id = 0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    except,
  input  logic                    except_thread,
  input  logic [`FE_IP_WIDTH-1:0] except_ip,
  input  fe_pkg::fill_t           fill,
  output fe_pkg::fetch_req_t      req,
  output fe_pkg::insn_t           head,
  input  logic                    pop
);

  localparam int idx_bits = $clog2(`FE_LINE_INSNS);
  localparam int ofs_bits = idx_bits + 2;
  localparam logic [`FE_IP_WIDTH-1:0] reset_ip =
    `FE_RESET_IP + `FE_IP_WIDTH'(thread_id) * `FE_THREAD_IP_STEP;

  logic [`FE_LINE_INSNS-1:0][`FE_INSN_WIDTH-1:0] buf_q;
  logic [`FE_IP_WIDTH-1:0] ip_q;
  logic [`FE_IP_WIDTH-1:0] req_addr_q;
  logic                    buf_valid_q;
  logic                    pend_q;
  logic                    discard_q;
  logic [idx_bits-1:0]     rd_idx;
  logic                    except_hit;
  logic                    fill_hit;

  // word offset of the pointer, so a redirect can start mid-line
  assign rd_idx     = ip_q[ofs_bits-1:2];
  assign except_hit = except && (except_thread == 1'(thread_id));
  assign fill_hit   = fill.valid && (fill.thread == 1'(thread_id)) && pend_q;

  assign req.valid = pend_q;
  assign req.addr  = req_addr_q;

  always_comb begin
    head.valid  = buf_valid_q;
    head.thread = 1'(thread_id);
    head.ip     = ip_q;
    head.word   = buf_q[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q        <= reset_ip;
      buf_valid_q <= 1'b0;
      pend_q      <= 1'b0;
      discard_q   <= 1'b0;
    end else if (except_hit) begin
      ip_q        <= except_ip;
      buf_valid_q <= 1'b0;
      // a fill still in flight carries the old line
      discard_q   <= pend_q && !fill_hit;
      if (fill_hit) begin
        pend_q <= 1'b0;
      end
    end else if (fill_hit) begin
      pend_q      <= 1'b0;
      discard_q   <= 1'b0;
      buf_valid_q <= !discard_q;
    end else if (pop) begin
      ip_q <= ip_q + `FE_IP_WIDTH'(4);
      if (rd_idx == idx_bits'(`FE_LINE_INSNS - 1)) begin
        buf_valid_q <= 1'b0;
      end
    end else if (!buf_valid_q && !pend_q) begin
      pend_q     <= 1'b1;
      req_addr_q <= {ip_q[`FE_IP_WIDTH-1:ofs_bits], {ofs_bits{1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (fill_hit) begin
      buf_q <= fill.line;
    end
  end

  a_pop_valid: assert property (
    @(posedge clk) disable iff (rst)
    pop |-> head.valid
  );

endmodule

// File: source/thread_arbiter.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module thread_arbiter (
  input  logic                               clk,
  input  logic                               rst,
  input  fe_pkg::insn_t [`FE_NUM_THREADS-1:0] heads,
  input  logic                               ready,
  output logic [`FE_NUM_THREADS-1:0]         pop,
  output fe_pkg::insn_t                      picked
);

  logic toggle_q;
  logic both;
  logic sel;

  assign both = heads[0].valid && heads[1].valid;
  // a lone valid head wins, two heads take turns
  assign sel = both ? toggle_q : heads[1].valid;

  always_comb begin
    picked       = heads[sel];
    picked.valid = heads[sel].valid && ready;
    pop          = '0;
    pop[sel]     = picked.valid;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      toggle_q <= 1'b0;
    end else if (both && ready) begin
      toggle_q <= !toggle_q;
    end
  end

endmodule

// File: source/insn_decoder.sv
`timescale 1ns/1ns

module insn_decoder (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,
  input  logic              except,
  input  logic              except_thread,
  input  fe_pkg::insn_t     insn,
  output logic              ready,
  output fe_pkg::dec_insn_t dec
);

  fe_pkg::dec_insn_t nxt;
  fe_pkg::opcode_e   op;

  assign ready = !dec.valid || !stall;

  always_comb begin
    case (insn.word[31:28])
      4'd0:    op = fe_pkg::op_nop;
      4'd1:    op = fe_pkg::op_alu;
      4'd2:    op = fe_pkg::op_load;
      4'd3:    op = fe_pkg::op_store;
      4'd4:    op = fe_pkg::op_branch;
      default: op = fe_pkg::op_illegal;
    endcase
  end

  always_comb begin
    // drop an instruction of the thread being redirected
    nxt.valid  = insn.valid && !(except && except_thread == insn.thread);
    nxt.thread = insn.thread;
    nxt.ip     = insn.ip;
    nxt.opcode = op;
    nxt.ra     = insn.word[27:22];
    nxt.rb     = insn.word[21:16];
    nxt.rt     = insn.word[15:10];
    nxt.rt_use = (op == fe_pkg::op_alu) || (op == fe_pkg::op_load);
    nxt.imm    = {{($bits(nxt.imm) - 10){insn.word[9]}}, insn.word[9:0]};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else if (ready) begin
      dec <= nxt;
    end else if (except && except_thread == dec.thread) begin
      dec.valid <= 1'b0;
    end
  end

  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (rst)
    stall && dec.valid && !(except && except_thread == dec.thread) |=> $stable(dec)
  );

endmodule

// File: source/front_end.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module front_end (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stall,
  input  logic                      except,
  input  logic                      except_thread,
  input  logic [`FE_IP_WIDTH-1:0]   except_ip,
  output logic                      mem_req,
  output logic [`FE_IP_WIDTH-1:0]   mem_addr,
  input  logic                      mem_ack,
  input  logic [`FE_LINE_WIDTH-1:0] mem_data,
  output fe_pkg::dec_insn_t         dec
);

  fe_pkg::fetch_req_t [`FE_NUM_THREADS-1:0] reqs;
  fe_pkg::insn_t [`FE_NUM_THREADS-1:0]      heads;
  logic [`FE_NUM_THREADS-1:0]               pops;
  fe_pkg::fill_t                            fill;
  fe_pkg::insn_t                            picked;
  logic                                     ready;

  line_fill_arbiter u_fill_arb (
    .clk(clk),
    .rst(rst),
    .thread_req(reqs),
    .mem_req(mem_req),
    .mem_addr(mem_addr),
    .mem_ack(mem_ack),
    .mem_data(mem_data),
    .fill(fill)
  );

  for (genvar i = 0; i < `FE_NUM_THREADS; i++) begin : g_thread
    fetch_thread #(.thread_id(i)) u_fetch (
      .clk(clk),
      .rst(rst),
      .except(except),
      .except_thread(except_thread),
      .except_ip(except_ip),
      .fill(fill),
      .req(reqs[i]),
      .head(heads[i]),
      .pop(pops[i])
    );
  end

  thread_arbiter u_thread_arb (
    .clk(clk),
    .rst(rst),
    .heads(heads),
    .ready(ready),
    .pop(pops),
    .picked(picked)
  );

  insn_decoder u_dec (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .except(except),
    .except_thread(except_thread),
    .insn(picked),
    .ready(ready),
    .dec(dec)
  );

endmodule

// File: sim/tb_front_end.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module tb_front_end;

  localparam int reset_cycles = 16;
  localparam int target_outputs = 300;
  // worst case per output with two threads, fills of up to 6 cycles and stall
  localparam int watchdog_cycles = reset_cycles + target_outputs * 13;

  logic                      clk;
  logic                      rst;
  logic                      stall;
  logic                      except;
  logic                      except_thread;
  logic [`FE_IP_WIDTH-1:0]   except_ip;
  logic                      mem_req;
  logic [`FE_IP_WIDTH-1:0]   mem_addr;
  logic                      mem_ack;
  logic [`FE_LINE_WIDTH-1:0] mem_data;
  fe_pkg::dec_insn_t         dec;

  int                         seed = 97;
  int                         cycle_cnt = 0;
  int                         out_count;
  logic [`FE_INSN_WIDTH-1:0]  mem_table [64];
  logic [`FE_IP_WIDTH-1:0]    next_ip [`FE_NUM_THREADS];
  logic [`FE_NUM_THREADS-1:0] seen;
  fe_pkg::dec_insn_t          prev_dec;
  logic                       prev_mem_req;
  logic [`FE_IP_WIDTH-1:0]    prev_mem_addr;

  front_end dut (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .except(except),
    .except_thread(except_thread),
    .except_ip(except_ip),
    .mem_req(mem_req),
    .mem_addr(mem_addr),
    .mem_ack(mem_ack),
    .mem_data(mem_data),
    .dec(dec)
  );

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // table is indexed by address bits 7:2
  function automatic logic [`FE_LINE_WIDTH-1:0] line_at(logic [`FE_IP_WIDTH-1:0] addr);
    logic [`FE_LINE_WIDTH-1:0] line;
    for (int i = 0; i < `FE_LINE_INSNS; i++) begin
      line[32*i +: 32] = mem_table[{addr[7:4], 2'(i)}];
    end
    return line;
  endfunction

  function automatic fe_pkg::dec_insn_t expected_dec(logic thread, logic [31:0] ip);
    fe_pkg::dec_insn_t d;
    logic [31:0]       w;
    w = mem_table[ip[7:2]];
    d.valid = 1'b1;
    d.thread = thread;
    d.ip = ip;
    d.opcode = (w[31:28] <= 4'd4) ? fe_pkg::opcode_e'(w[31:28]) : fe_pkg::op_illegal;
    d.ra = w[27:22];
    d.rb = w[21:16];
    d.rt = w[15:10];
    d.rt_use = d.opcode inside {fe_pkg::op_alu, fe_pkg::op_load};
    d.imm = 32'($signed(w[9:0]));
    return d;
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // four-phase memory slave that acks after 1 to 6 cycles
  initial begin : mem_model
    int delay;
    mem_ack = 1'b0;
    mem_data = '0;
    forever begin
      @(posedge clk);
      #2;
      if (mem_req && !rst) begin
        delay = 1 + {$random(seed)} % 6;
        repeat (delay) @(posedge clk);
        #2;
        mem_data = line_at(mem_addr);
        mem_ack = 1'b1;
        do begin
          @(posedge clk);
          #2;
        end while (mem_req);
        // ack may trail the falling req by up to 2 cycles
        delay = {$random(seed)} % 3;
        repeat (delay) begin
          @(posedge clk);
          #2;
        end
        mem_ack = 1'b0;
      end
    end
  end

  initial begin
    int n;
    for (int i = 0; i < 64; i++) begin
      mem_table[i] = $random(seed);
    end
    rst = 1'b1;
    stall = 1'b0;
    except = 1'b0;
    except_thread = 1'b0;
    except_ip = '0;
    n = 0;
    repeat (reset_cycles) @(posedge clk);
    #2 rst = 1'b0;
    while (out_count < target_outputs) begin
      @(posedge clk);
      #2;
      n++;
      stall = ({$random(seed)} % 4) == 0;
      except = 1'b0;
      // mid-line redirects that alternate between the threads
      if (n % 150 == 0) begin
        except = 1'b1;
        except_thread = 1'((n / 150) % 2);
        except_ip = 32'h0000_2000 + (({$random(seed)} % 64) << 2);
      end
    end
    stall = 1'b0;
    except = 1'b0;
    if (seen == 2'b11) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      report_failure($sformatf("CHECK FAILED both_threads: expected seen 11, actual %b", seen));
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    report_failure($sformatf("timeout: fewer than %0d decoded outputs within %0d cycles",
                             target_outputs, watchdog_cycles));
  end

  // expected pointer per thread, stepped on each consumed output
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    prev_dec <= dec;
    prev_mem_req <= mem_req;
    prev_mem_addr <= mem_addr;
    if (rst) begin
      next_ip[0] <= `FE_RESET_IP;
      next_ip[1] <= `FE_RESET_IP + `FE_THREAD_IP_STEP;
      seen <= '0;
      out_count <= 0;
    end else begin
      if (dec.valid && !stall) begin
        next_ip[dec.thread] <= dec.ip + 32'd4;
        seen[dec.thread] <= 1'b1;
        out_count <= out_count + 1;
      end
      // redirect wins over the step of the same cycle
      if (except) begin
        next_ip[except_thread] <= except_ip;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    (cycle_cnt > 0) && (rst || $past(rst)) |-> !mem_req && !dec.valid)
    else report_failure($sformatf(
      "CHECK FAILED reset_quiet: expected mem_req 0 dec.valid 0, actual %b %b",
      $sampled(mem_req), $sampled(dec.valid)));

  a_req_held: assert property (@(posedge clk) disable iff (rst)
    $fell(mem_req) |-> $past(mem_ack))
    else report_failure("CHECK FAILED req_held: expected mem_ack 1 before mem_req fell, actual 0");

  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req && prev_mem_req |-> mem_addr == prev_mem_addr)
    else report_failure($sformatf("CHECK FAILED addr_stable: expected %h, actual %h",
                                  $sampled(prev_mem_addr), $sampled(mem_addr)));

  a_addr_aligned: assert property (@(posedge clk) disable iff (rst)
    mem_req |-> mem_addr[3:0] == 4'h0)
    else report_failure($sformatf("CHECK FAILED addr_aligned: expected low bits 0, actual %h",
                                  $sampled(mem_addr)));

  a_no_rise_on_ack: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) |-> !mem_ack)
    else report_failure("CHECK FAILED no_rise_on_ack: expected mem_ack 0 at mem_req rise, actual 1");

  a_order: assert property (@(posedge clk) disable iff (rst)
    dec.valid |-> dec.ip == next_ip[dec.thread])
    else report_failure($sformatf("CHECK FAILED order: thread %0d expected ip %h, actual %h",
                                  $sampled(dec.thread), $sampled(next_ip[dec.thread]),
                                  $sampled(dec.ip)));

  a_decode: assert property (@(posedge clk) disable iff (rst)
    dec.valid |-> dec == expected_dec(dec.thread, dec.ip))
    else report_failure($sformatf("CHECK FAILED decode: expected %h, actual %h",
                                  expected_dec($sampled(dec.thread), $sampled(dec.ip)),
                                  $sampled(dec)));

  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    stall && dec.valid && !(except && except_thread == dec.thread) |=> dec == prev_dec)
    else report_failure($sformatf("CHECK FAILED stall_hold: expected %h, actual %h",
                                  $sampled(prev_dec), $sampled(dec)));

endmodule

// File: sources.f
+incdir+include
source/fe_pkg.sv
source/line_fill_arbiter.sv
source/fetch_thread.sv
source/thread_arbiter.sv
source/insn_decoder.sv
source/front_end.sv
sim/tb_front_end.sv

// File: Bender.yml
package:
  name: front_end

export_include_dirs:
  - include

sources:
  - source/fe_pkg.sv
  - source/line_fill_arbiter.sv
  - source/fetch_thread.sv
  - source/thread_arbiter.sv
  - source/insn_decoder.sv
  - source/front_end.sv
  - target: simulation
    files:
      - sim/tb_front_end.sv
